//--- verilog/ccc_pkg.sv
// CCC handler shared definitions
package ccc_pkg;

  // 8-bit command code, bit 7 marks a direct CCC
  typedef logic [7:0] ccc_code_t;

  // Broadcast commands
  localparam ccc_code_t CCC_BCAST_ENEC    = 8'h00;
  localparam ccc_code_t CCC_BCAST_DISEC   = 8'h01;
  localparam ccc_code_t CCC_BCAST_RSTDAA  = 8'h06;
  localparam ccc_code_t CCC_BCAST_SETMWL  = 8'h09;
  localparam ccc_code_t CCC_BCAST_SETMRL  = 8'h0A;
  localparam ccc_code_t CCC_BCAST_SETAASA = 8'h29;

  // Direct commands
  localparam ccc_code_t CCC_DIRECT_ENEC   = 8'h80;
  localparam ccc_code_t CCC_DIRECT_DISEC  = 8'h81;
  localparam ccc_code_t CCC_DIRECT_SETMWL = 8'h89;
  localparam ccc_code_t CCC_DIRECT_SETMRL = 8'h8A;
  localparam ccc_code_t CCC_DIRECT_GETMWL = 8'h8B;
  localparam ccc_code_t CCC_DIRECT_GETMRL = 8'h8C;
  localparam ccc_code_t CCC_DIRECT_GETPID = 8'h8D;
  localparam ccc_code_t CCC_DIRECT_GETBCR = 8'h8E;
  localparam ccc_code_t CCC_DIRECT_GETDCR = 8'h8F;

  // I3C broadcast address
  localparam logic [6:0] RSVD_ADDR = 7'h7E;

  // Longest GET response, GETPID
  localparam int unsigned GET_MAX_BYTES = 6;
  localparam int unsigned GET_CNT_W     = $clog2(GET_MAX_BYTES + 1);

  // Third GETMRL byte, max IBI payload
  localparam logic [7:0] MRL_IBI_SIZE = 8'hFF;

  // From the bus layer
  typedef struct packed {
    logic       rx_done;
    logic [7:0] rx_data;
    logic       tx_done;
    logic       start_det;
    logic       rstart_det;
    logic       stop_det;
  } bus_rsp_t;

  // To the bus layer, held until the matching done
  typedef struct packed {
    logic       rx_req_bit;
    logic       rx_req_byte;
    logic       tx_req_bit;
    logic       tx_req_byte;
    logic [7:0] tx_value;
  } bus_req_t;

  // Addresses the target answers to
  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_valid;
    logic [6:0] dyn_addr;
    logic       dyn_valid;
  } target_addr_t;

  // Fixed device identity
  typedef struct packed {
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [47:0] pid;
  } dev_info_t;

  // One received data byte
  typedef struct packed {
    logic       valid;
    logic [2:0] index;
    logic [7:0] data;
  } rx_byte_t;

  // Settings written by SET commands
  typedef struct packed {
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic        mwl_we;
    logic        mrl_we;
    logic        ev_ibi;
    logic        ev_crr;
    logic        ev_hj;
  } ccc_cfg_t;

  // Address events for the target
  typedef struct packed {
    logic       rstdaa;
    logic       set_da;
    logic [6:0] da;
  } addr_event_t;

endpackage

//--- verilog/ccc_frame_fsm.sv
// CCC framing state machine
`timescale 1ns/100ps

module ccc_frame_fsm
  import ccc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  ccc_code_t    ccc_i,
  input  logic         ccc_valid_i,
  input  bus_rsp_t     bus_rsp_i,
  input  target_addr_t addr_i,
  input  logic [7:0]   tx_byte_i,
  input  logic         tx_last_i,
  output bus_req_t     bus_req_o,
  output ccc_code_t    cmd_o,
  output rx_byte_t     rx_byte_o,
  output logic         bcast_end_o,
  output logic         tx_load_o,
  output logic         tx_next_o,
  output logic         done_o
);

  typedef enum logic [3:0] {
    WaitCcc,
    RxTbit,
    RxData,
    RxDataTbit,
    RxDirectByte,
    RxDirectAddr,
    TxAddrAck,
    TxData,
    TxDataTbit,
    IgnoreUntilSr,
    DoneCcc
  } state_e;

  state_e     state_q;
  state_e     state_d;
  ccc_code_t  cmd_q;
  logic [7:0] data_q;
  logic [2:0] idx_q;
  logic       rnw_q;
  logic       last_q;
  logic       is_direct;
  logic       sr_det;
  logic [6:0] rx_addr;
  logic       addr_hit;

  assign is_direct = cmd_q[7];
  assign rx_addr   = bus_rsp_i.rx_data[7:1];

  // Some monitors flag Sr as a plain START
  assign sr_det = bus_rsp_i.rstart_det | bus_rsp_i.start_det;

  // Dynamic address wins once assigned
  always_comb begin : addr_match
    if (rx_addr == RSVD_ADDR) begin
      addr_hit = 1'b0;
    end else if (addr_i.dyn_valid) begin
      addr_hit = (rx_addr == addr_i.dyn_addr);
    end else begin
      addr_hit = addr_i.sta_valid && (rx_addr == addr_i.sta_addr);
    end
  end

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      WaitCcc: begin
        if (ccc_valid_i) state_d = RxTbit;
      end
      // T-bit of the command code byte
      RxTbit: begin
        if (bus_rsp_i.rx_done) state_d = is_direct ? RxDirectByte : RxData;
      end
      RxData: begin
        if (is_direct && sr_det) state_d = RxDirectAddr;
        else if (bus_rsp_i.rx_done) state_d = RxDataTbit;
      end
      RxDataTbit: begin
        if (bus_rsp_i.rx_done) state_d = RxData;
      end
      // Direct CCC, target address follows Sr
      RxDirectByte: begin
        if (sr_det) state_d = RxDirectAddr;
      end
      RxDirectAddr: begin
        if (bus_rsp_i.rx_done) state_d = addr_hit ? TxAddrAck : IgnoreUntilSr;
      end
      TxAddrAck: begin
        if (bus_rsp_i.tx_done) state_d = rnw_q ? TxData : RxData;
      end
      TxData: begin
        if (sr_det) state_d = RxDirectAddr;
        else if (bus_rsp_i.tx_done) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (bus_rsp_i.tx_done) state_d = last_q ? IgnoreUntilSr : TxData;
      end
      // Not addressed, stay silent
      IgnoreUntilSr: begin
        if (sr_det) state_d = RxDirectAddr;
      end
      DoneCcc: begin
        state_d = WaitCcc;
      end
      default: begin
        state_d = WaitCcc;
      end
    endcase
  end

  // Requests follow the state, drop once the state moves on
  always_comb begin : bus_requests
    bus_req_o = '0;
    unique case (state_q)
      RxTbit, RxDataTbit: begin
        bus_req_o.rx_req_bit = 1'b1;
      end
      RxData, RxDirectAddr: begin
        bus_req_o.rx_req_byte = 1'b1;
      end
      TxAddrAck: begin
        // ACK is driven low
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value   = 8'h00;
      end
      TxData: begin
        bus_req_o.tx_req_byte = 1'b1;
        bus_req_o.tx_value    = tx_byte_i;
      end
      TxDataTbit: begin
        // High while more bytes follow
        bus_req_o.tx_req_bit = 1'b1;
        bus_req_o.tx_value   = {7'b0, ~last_q};
      end
      default: begin
      end
    endcase
  end

  // STOP ends the CCC from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= WaitCcc;
    end else if (bus_rsp_i.stop_det) begin
      state_q <= DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      cmd_q  <= '0;
      idx_q  <= '0;
      rnw_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      if (state_q == WaitCcc && ccc_valid_i) begin
        cmd_q <= ccc_i;
      end
      // Index restarts per CCC and per addressed target
      if ((state_q == WaitCcc && ccc_valid_i) ||
          (state_q == TxAddrAck && bus_rsp_i.tx_done)) begin
        idx_q <= '0;
      end else if (state_q == RxDataTbit && bus_rsp_i.rx_done && idx_q != 3'd7) begin
        idx_q <= idx_q + 3'd1;
      end
      if (state_q == RxDirectAddr && bus_rsp_i.rx_done) begin
        rnw_q <= bus_rsp_i.rx_data[0];
      end
      // Count moves on with tx_next, so keep the last flag
      if (state_q == TxData && bus_rsp_i.tx_done) begin
        last_q <= tx_last_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_reg
    if (state_q == RxData && bus_rsp_i.rx_done) begin
      data_q <= bus_rsp_i.rx_data;
    end
  end

  assign cmd_o           = cmd_q;
  assign rx_byte_o.valid = (state_q == RxDataTbit) && bus_rsp_i.rx_done;
  assign rx_byte_o.index = idx_q;
  assign rx_byte_o.data  = data_q;
  assign bcast_end_o     = (state_q == RxTbit) && bus_rsp_i.rx_done && !is_direct;
  assign tx_load_o       = (state_q == TxAddrAck) && bus_rsp_i.tx_done && rnw_q;
  assign tx_next_o       = (state_q == TxData) && bus_rsp_i.tx_done;
  assign done_o          = (state_q == DoneCcc);

endmodule

//--- verilog/ccc_get_mux.sv
// GET response byte selection
`timescale 1ns/100ps

module ccc_get_mux
  import ccc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ccc_code_t  cmd_i,
  input  logic       tx_load_i,
  input  logic       tx_next_i,
  input  dev_info_t  dev_info_i,
  input  ccc_cfg_t   cfg_i,
  output logic [7:0] tx_byte_o,
  output logic       tx_last_o
);

  logic [GET_CNT_W-1:0] cnt_q;
  logic [GET_CNT_W-1:0] cnt_len;
  logic [5:0]           pid_lsb;

  // Response length per GET code
  always_comb begin : len_sel
    case (cmd_i)
      CCC_DIRECT_GETBCR, CCC_DIRECT_GETDCR: cnt_len = GET_CNT_W'(1);
      CCC_DIRECT_GETMWL:                    cnt_len = GET_CNT_W'(2);
      CCC_DIRECT_GETMRL:                    cnt_len = GET_CNT_W'(3);
      CCC_DIRECT_GETPID:                    cnt_len = GET_CNT_W'(GET_MAX_BYTES);
      default:                              cnt_len = '0;
    endcase
  end

  // Bytes left to send, current one included
  always_ff @(posedge clk_i or negedge rst_ni) begin : byte_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (tx_load_i) begin
      cnt_q <= cnt_len;
    end else if (tx_next_i && cnt_q != '0) begin
      cnt_q <= cnt_q - GET_CNT_W'(1);
    end
  end

  // PID goes out MSB first, count 6 picks bits 47:40
  assign pid_lsb = {cnt_q - GET_CNT_W'(1), 3'b000};

  always_comb begin : byte_sel
    tx_byte_o = 8'h00;
    case (cmd_i)
      CCC_DIRECT_GETBCR: tx_byte_o = dev_info_i.bcr;
      CCC_DIRECT_GETDCR: tx_byte_o = dev_info_i.dcr;
      CCC_DIRECT_GETMWL: begin
        tx_byte_o = (cnt_q == GET_CNT_W'(2)) ? cfg_i.mwl[15:8] : cfg_i.mwl[7:0];
      end
      CCC_DIRECT_GETMRL: begin
        if (cnt_q == GET_CNT_W'(3)) tx_byte_o = cfg_i.mrl[15:8];
        else if (cnt_q == GET_CNT_W'(2)) tx_byte_o = cfg_i.mrl[7:0];
        else tx_byte_o = MRL_IBI_SIZE;
      end
      CCC_DIRECT_GETPID: begin
        if (cnt_q != '0) tx_byte_o = dev_info_i.pid[pid_lsb +: 8];
      end
      default: begin
        tx_byte_o = 8'h00;
      end
    endcase
  end

  // Zero count also ends a read of a non-GET code
  assign tx_last_o = (cnt_q <= GET_CNT_W'(1));

endmodule

//--- verilog/ccc_set_regs.sv
// CCC settings register block
`timescale 1ns/100ps

module ccc_set_regs
  import ccc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  ccc_code_t    cmd_i,
  input  rx_byte_t     rx_byte_i,
  input  logic         bcast_end_i,
  input  target_addr_t addr_i,
  output ccc_cfg_t     cfg_o,
  output addr_event_t  addr_evt_o
);

  ccc_cfg_t    cfg_q;
  addr_event_t evt_q;
  logic        is_mwl;
  logic        is_mrl;
  logic        is_enec;
  logic        is_disec;
  logic        byte0;
  logic        byte1;
  logic        aasa_hit;

  // Broadcast and direct forms share the handling
  assign is_mwl   = cmd_i inside {CCC_BCAST_SETMWL, CCC_DIRECT_SETMWL};
  assign is_mrl   = cmd_i inside {CCC_BCAST_SETMRL, CCC_DIRECT_SETMRL};
  assign is_enec  = cmd_i inside {CCC_BCAST_ENEC, CCC_DIRECT_ENEC};
  assign is_disec = cmd_i inside {CCC_BCAST_DISEC, CCC_DIRECT_DISEC};

  assign byte0 = rx_byte_i.valid && (rx_byte_i.index == 3'd0);
  assign byte1 = rx_byte_i.valid && (rx_byte_i.index == 3'd1);

  // SETAASA only if a static address exists
  assign aasa_hit = bcast_end_i && (cmd_i == CCC_BCAST_SETAASA) && addr_i.sta_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin : cfg_reg
    if (!rst_ni) begin
      cfg_q <= '0;
    end else begin
      cfg_q.mwl_we <= 1'b0;
      cfg_q.mrl_we <= 1'b0;

      // MSB first, byte 1 completes the value
      if (is_mwl && byte0) begin
        cfg_q.mwl[15:8] <= rx_byte_i.data;
      end
      if (is_mwl && byte1) begin
        cfg_q.mwl[7:0] <= rx_byte_i.data;
        cfg_q.mwl_we   <= 1'b1;
      end
      if (is_mrl && byte0) begin
        cfg_q.mrl[15:8] <= rx_byte_i.data;
      end
      if (is_mrl && byte1) begin
        cfg_q.mrl[7:0] <= rx_byte_i.data;
        cfg_q.mrl_we   <= 1'b1;
      end

      // Event bits: 0 IBI, 1 controller role, 3 hot-join
      if (is_enec && byte0) begin
        cfg_q.ev_ibi <= cfg_q.ev_ibi | rx_byte_i.data[0];
        cfg_q.ev_crr <= cfg_q.ev_crr | rx_byte_i.data[1];
        cfg_q.ev_hj  <= cfg_q.ev_hj | rx_byte_i.data[3];
      end
      if (is_disec && byte0) begin
        cfg_q.ev_ibi <= cfg_q.ev_ibi & ~rx_byte_i.data[0];
        cfg_q.ev_crr <= cfg_q.ev_crr & ~rx_byte_i.data[1];
        cfg_q.ev_hj  <= cfg_q.ev_hj & ~rx_byte_i.data[3];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : evt_reg
    if (!rst_ni) begin
      evt_q <= '0;
    end else begin
      evt_q.rstdaa <= bcast_end_i && (cmd_i == CCC_BCAST_RSTDAA);
      evt_q.set_da <= aasa_hit;
      // Static address becomes the dynamic one
      if (aasa_hit) begin
        evt_q.da <= addr_i.sta_addr;
      end
    end
  end

  assign cfg_o      = cfg_q;
  assign addr_evt_o = evt_q;

endmodule

//--- verilog/ccc_top.sv
// I3C target CCC handler
`timescale 1ns/100ps

module ccc_top
  import ccc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  ccc_code_t    ccc_i,
  input  logic         ccc_valid_i,
  input  bus_rsp_t     bus_rsp_i,
  output bus_req_t     bus_req_o,
  input  target_addr_t addr_i,
  input  dev_info_t    dev_info_i,
  output logic         done_o,
  output ccc_cfg_t     cfg_o,
  output addr_event_t  addr_evt_o
);

  ccc_code_t  cmd;
  rx_byte_t   rx_byte;
  logic       bcast_end;
  logic       tx_load;
  logic       tx_next;
  logic [7:0] tx_byte;
  logic       tx_last;

  // Framing and address match
  ccc_frame_fsm u_frame_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_i       (ccc_i),
    .ccc_valid_i (ccc_valid_i),
    .bus_rsp_i   (bus_rsp_i),
    .addr_i      (addr_i),
    .tx_byte_i   (tx_byte),
    .tx_last_i   (tx_last),
    .bus_req_o   (bus_req_o),
    .cmd_o       (cmd),
    .rx_byte_o   (rx_byte),
    .bcast_end_o (bcast_end),
    .tx_load_o   (tx_load),
    .tx_next_o   (tx_next),
    .done_o      (done_o)
  );

  // GET data, reads back stored MWL and MRL
  ccc_get_mux u_get_mux (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_i      (cmd),
    .tx_load_i  (tx_load),
    .tx_next_i  (tx_next),
    .dev_info_i (dev_info_i),
    .cfg_i      (cfg_o),
    .tx_byte_o  (tx_byte),
    .tx_last_o  (tx_last)
  );

  // SET registers and address events
  ccc_set_regs u_set_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .rx_byte_i   (rx_byte),
    .bcast_end_i (bcast_end),
    .addr_i      (addr_i),
    .cfg_o       (cfg_o),
    .addr_evt_o  (addr_evt_o)
  );

endmodule

//--- tests/ccc_properties.sv
// CCC handler bound checks
`timescale 1ns/100ps

module ccc_properties
  import ccc_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input bus_rsp_t    bus_rsp_i,
  input bus_req_t    bus_req_i,
  input logic        done_i,
  input ccc_cfg_t    cfg_i,
  input addr_event_t addr_evt_i
);

  // Failure tallies, one per assertion
  int unsigned onehot_fails    = 0;
  int unsigned done_len_fails  = 0;
  int unsigned done_stop_fails = 0;
  int unsigned reset_fails     = 0;

  // One bus request at a time
  req_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bus_req_i.rx_req_bit, bus_req_i.rx_req_byte,
              bus_req_i.tx_req_bit, bus_req_i.tx_req_byte}))
  else begin
    onehot_fails++;
    $error("more than one bus request is active");
  end

  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
  else begin
    done_len_fails++;
    $error("done_o stayed high for more than one cycle");
  end

  // STOP leads straight to done
  done_after_stop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_i.stop_det |=> done_i)
  else begin
    done_stop_fails++;
    $error("done_o did not follow stop_det");
  end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (bus_req_i == '0 && !done_i && cfg_i == '0 && addr_evt_i == '0))
  else begin
    reset_fails++;
    $error("outputs active while reset is asserted");
  end

endmodule

bind ccc_top ccc_properties bind_ccc_properties (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .bus_rsp_i  (bus_rsp_i),
  .bus_req_i  (bus_req_o),
  .done_i     (done_o),
  .cfg_i      (cfg_o),
  .addr_evt_i (addr_evt_o)
);

//--- tests/tb_ccc.sv
// CCC handler testbench
`timescale 1ns/100ps

module tb_ccc
  import ccc_pkg::*;
();

  // Request kinds answered by the bus model
  localparam int RX_BIT  = 0;
  localparam int RX_BYTE = 1;
  localparam int TX_BIT  = 2;
  localparam int TX_BYTE = 3;

  localparam logic [6:0] STA_ADDR   = 7'h2A;
  localparam logic [6:0] DYN_ADDR   = 7'h35;
  localparam int         WAIT_LIMIT = 64;

  logic         clk_i;
  logic         rst_ni;
  ccc_code_t    ccc;
  logic         ccc_valid;
  bus_rsp_t     bus_rsp;
  bus_req_t     bus_req;
  target_addr_t addr;
  dev_info_t    dev_info;
  logic         done;
  ccc_cfg_t     cfg;
  addr_event_t  addr_evt;

  int          errors    = 0;
  int          checks    = 0;
  int          ncases    = 0;
  logic        timed_out = 1'b0;
  logic [31:0] rnd_state = 32'h6892_603a;

  // Pulse and request tallies over the whole run
  int mwl_we_cnt = 0;
  int mrl_we_cnt = 0;
  int rstdaa_cnt = 0;
  int set_da_cnt = 0;
  int tx_req_cnt = 0;

  // Current case from one line of the cases file
  string       kind;
  ccc_code_t   code;
  logic [7:0]  addr_byte;
  int          nbytes;
  logic [7:0]  dat [6];
  logic [15:0] exp_mwl;
  logic [15:0] exp_mrl;
  logic [2:0]  exp_ev;
  int          exp_wm;
  int          exp_wr;
  int          exp_rd;
  int          exp_sd;

  ccc_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_i       (ccc),
    .ccc_valid_i (ccc_valid),
    .bus_rsp_i   (bus_rsp),
    .bus_req_o   (bus_req),
    .addr_i      (addr),
    .dev_info_i  (dev_info),
    .done_o      (done),
    .cfg_o       (cfg),
    .addr_evt_o  (addr_evt)
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Counts pulses and tx request cycles in mid-cycle
  always @(negedge clk_i) begin : pulse_monitor
    if (cfg.mwl_we) mwl_we_cnt <= mwl_we_cnt + 1;
    if (cfg.mrl_we) mrl_we_cnt <= mrl_we_cnt + 1;
    if (addr_evt.rstdaa) rstdaa_cnt <= rstdaa_cnt + 1;
    if (addr_evt.set_da) set_da_cnt <= set_da_cnt + 1;
    if (bus_req.tx_req_bit || bus_req.tx_req_byte) tx_req_cnt <= tx_req_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic req_active(input int req_kind);
    case (req_kind)
      RX_BIT:  return bus_req.rx_req_bit;
      RX_BYTE: return bus_req.rx_req_byte;
      TX_BIT:  return bus_req.tx_req_bit;
      default: return bus_req.tx_req_byte;
    endcase
  endfunction

  // Bus model answers one request after 1 to 4 cycles
  task automatic serve_req(input int req_kind, input logic [7:0] rx_value,
                           output logic [7:0] tx_seen);
    int n;
    int delay;
    n = 0;
    tx_seen = 8'h00;
    if (timed_out) return;
    @(negedge clk_i);
    while (!req_active(req_kind) && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!req_active(req_kind)) begin
      $display("timeout at %0t: the DUT never raised request kind %0d", $time, req_kind);
      errors++;
      timed_out = 1'b1;
      return;
    end
    tx_seen = bus_req.tx_value;
    rnd_state = xorshift32(rnd_state);
    delay = 1 + int'(rnd_state % 32'd4);
    repeat (delay) @(posedge clk_i);
    if (req_kind == RX_BIT || req_kind == RX_BYTE) begin
      bus_rsp.rx_done <= 1'b1;
      bus_rsp.rx_data <= rx_value;
    end else begin
      bus_rsp.tx_done <= 1'b1;
    end
    @(posedge clk_i);
    bus_rsp.rx_done <= 1'b0;
    bus_rsp.tx_done <= 1'b0;
  endtask

  task automatic pulse_rstart();
    if (timed_out) return;
    @(posedge clk_i);
    bus_rsp.rstart_det <= 1'b1;
    @(posedge clk_i);
    bus_rsp.rstart_det <= 1'b0;
  endtask

  // Sends a STOP and waits for done_o
  task automatic stop_and_wait_done();
    int n;
    n = 0;
    if (timed_out) return;
    @(posedge clk_i);
    bus_rsp.stop_det <= 1'b1;
    @(posedge clk_i);
    bus_rsp.stop_det <= 1'b0;
    @(negedge clk_i);
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!done) begin
      $display("timeout at %0t: done_o never pulsed after the STOP", $time);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case();
    logic [7:0] seen;
    int         i;
    int         base_wm;
    int         base_wr;
    int         base_rd;
    int         base_sd;
    int         base_tx;
    base_wm = mwl_we_cnt;
    base_wr = mrl_we_cnt;
    base_rd = rstdaa_cnt;
    base_sd = set_da_cnt;
    base_tx = tx_req_cnt;
    @(posedge clk_i);
    ccc       <= code;
    ccc_valid <= 1'b1;
    @(posedge clk_i);
    ccc_valid <= 1'b0;
    // T-bit of the command code byte
    serve_req(RX_BIT, 8'h00, seen);
    if (kind != "bcast") begin
      pulse_rstart();
      serve_req(RX_BYTE, addr_byte, seen);
    end
    if (kind == "write" || kind == "read") begin
      serve_req(TX_BIT, 8'h00, seen);
      check_value("address ACK tx_value", 64'(seen), 64'h0);
    end
    for (i = 0; i < nbytes; i++) begin
      if (kind == "read") begin
        serve_req(TX_BYTE, 8'h00, seen);
        check_value($sformatf("tx_value byte %0d", i), 64'(seen), 64'(dat[i]));
        serve_req(TX_BIT, 8'h00, seen);
        check_value($sformatf("T-bit after byte %0d", i), 64'(seen),
                    (i < nbytes - 1) ? 64'h1 : 64'h0);
      end else if (kind != "miss") begin
        serve_req(RX_BYTE, dat[i], seen);
        serve_req(RX_BIT, 8'h00, seen);
      end
    end
    stop_and_wait_done();
    if (timed_out) return;
    check_value("cfg_o.mwl", 64'(cfg.mwl), 64'(exp_mwl));
    check_value("cfg_o.mrl", 64'(cfg.mrl), 64'(exp_mrl));
    check_value("cfg_o event enables", 64'({cfg.ev_hj, cfg.ev_crr, cfg.ev_ibi}), 64'(exp_ev));
    check_value("mwl_we pulses", 64'(mwl_we_cnt - base_wm), 64'(exp_wm));
    check_value("mrl_we pulses", 64'(mrl_we_cnt - base_wr), 64'(exp_wr));
    check_value("rstdaa pulses", 64'(rstdaa_cnt - base_rd), 64'(exp_rd));
    check_value("set_da pulses", 64'(set_da_cnt - base_sd), 64'(exp_sd));
    if (exp_sd != 0) begin
      check_value("addr_evt_o.da", 64'(addr_evt.da), 64'(STA_ADDR));
    end
    // Target not addressed stays off the bus
    if (kind == "miss") begin
      check_value("tx request cycles", 64'(tx_req_cnt - base_tx), 64'h0);
    end
  endtask

  initial begin : main
    int    fd;
    int    n;
    string line;
    rst_ni    = 1'b0;
    ccc       = '0;
    ccc_valid = 1'b0;
    bus_rsp   = '0;
    addr      = '{sta_addr: STA_ADDR, sta_valid: 1'b1, dyn_addr: DYN_ADDR, dyn_valid: 1'b1};
    dev_info  = '{bcr: 8'hA6, dcr: 8'h44, pid: 48'h5A17_C3E0_9B42};
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("bus_req_o after reset", 64'(bus_req), 64'h0);
    check_value("done_o after reset", 64'(done), 64'h0);
    check_value("cfg_o after reset", 64'(cfg), 64'h0);
    check_value("addr_evt_o after reset", 64'(addr_evt), 64'h0);

    fd = $fopen("tests/ccc_cases.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open tests/ccc_cases.txt");
      errors++;
    end else begin
      while (!timed_out) begin
        n = $fscanf(fd, "%s", kind);
        if (n != 1) break;
        if (kind.substr(0, 0) == "#") begin
          void'($fgets(line, fd));
        end else begin
          n = $fscanf(fd, "%h %h %d %h %h %h %h %h %h %h %h %h %d %d %d %d",
                      code, addr_byte, nbytes, dat[0], dat[1], dat[2], dat[3], dat[4],
                      dat[5], exp_mwl, exp_mrl, exp_ev, exp_wm, exp_wr, exp_rd, exp_sd);
          if (n != 16) begin
            $display("error: case line of kind %s has missing fields", kind);
            errors++;
            break;
          end
          if (kind != "bcast" && kind != "write" && kind != "read" && kind != "miss") begin
            $display("error: unknown case kind %s", kind);
            errors++;
          end else begin
            ncases++;
            run_case();
          end
        end
      end
      $fclose(fd);
    end

    // Last done pulse still has two property cycles to go
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);

    // Add the bound assertion failure tallies
    errors = errors + int'(dut_i.bind_ccc_properties.onehot_fails)
                    + int'(dut_i.bind_ccc_properties.done_len_fails)
                    + int'(dut_i.bind_ccc_properties.done_stop_fails)
                    + int'(dut_i.bind_ccc_properties.reset_fails);
    $display("cases %0d, checks %0d, errors %0d", ncases, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tests/ccc_cases.txt
# kind ccc addr n d0 d1 d2 d3 d4 d5 mwl mrl ev mwl_we mrl_we rstdaa set_da
# addr is {target, rnw}, d0..d5 are SET data or expected GET bytes, ev is {hj, crr, ibi}
bcast 09 00 2 01 20 00 00 00 00 0120 0000 0 1 0 0 0
bcast 0A 00 2 02 40 00 00 00 00 0120 0240 0 0 1 0 0
write 89 6A 2 03 00 00 00 00 00 0300 0240 0 1 0 0 0
write 8A 6A 3 00 80 77 00 00 00 0300 0080 0 0 1 0 0
read  8B 6B 2 03 00 00 00 00 00 0300 0080 0 0 0 0 0
read  8C 6B 3 00 80 FF 00 00 00 0300 0080 0 0 0 0 0
read  8E 6B 1 A6 00 00 00 00 00 0300 0080 0 0 0 0 0
read  8F 6B 1 44 00 00 00 00 00 0300 0080 0 0 0 0 0
read  8D 6B 6 5A 17 C3 E0 9B 42 0300 0080 0 0 0 0 0
bcast 00 00 1 0B 00 00 00 00 00 0300 0080 7 0 0 0 0
bcast 01 00 1 02 00 00 00 00 00 0300 0080 5 0 0 0 0
write 81 6A 1 09 00 00 00 00 00 0300 0080 0 0 0 0 0
write 80 6A 1 F6 00 00 00 00 00 0300 0080 2 0 0 0 0
miss  89 54 0 00 00 00 00 00 00 0300 0080 2 0 0 0 0
miss  8B FD 0 00 00 00 00 00 00 0300 0080 2 0 0 0 0
bcast 06 00 0 00 00 00 00 00 00 0300 0080 2 0 0 1 0
bcast 29 00 0 00 00 00 00 00 00 0300 0080 2 0 0 0 1
bcast 09 00 3 AB CD EF 00 00 00 ABCD 0080 2 1 0 0 0
read  8B 6B 2 AB CD 00 00 00 00 ABCD 0080 2 0 0 0 0
write 8A 6A 1 55 00 00 00 00 00 ABCD 5580 2 0 0 0 0
read  8C 6B 3 55 80 FF 00 00 00 ABCD 5580 2 0 0 0 0

//--- sim.f
verilog/ccc_pkg.sv
verilog/ccc_frame_fsm.sv
verilog/ccc_get_mux.sv
verilog/ccc_set_regs.sv
verilog/ccc_top.sv
tests/ccc_properties.sv
tests/tb_ccc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CCC handler testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_ccc -o sim_ccc || exit 1
out=$(./obj_dir/sim_ccc +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1
